// ==== src/alu_copro_pkg.sv ====
// Shared constants and types for the ALU coprocessor
// Referenced by scoped name from the RTL and the testbench
`default_nettype none

package alu_copro_pkg;

    localparam int data_w     = 32;   // Datapath width
    localparam int reg_num    = 16;   // Register bank depth
    localparam int reg_aw     = 4;    // Register address width
    localparam int done_cnt_w = 16;   // Completed-command counter width

    // APB address map, byte addresses
    localparam logic [7:0] addr_reg_top = 8'h3C;  // r0..r15 at 0x00..0x3C
    localparam logic [7:0] addr_cmd     = 8'h40;  // Command word, write only
    localparam logic [7:0] addr_status  = 8'h44;  // Status word, read only

    // ALU opcodes, 11 to 15 reserved
    typedef enum logic [3:0] {
        op_add  = 4'd0,
        op_sub  = 4'd1,
        op_and  = 4'd2,
        op_or   = 4'd3,
        op_xor  = 4'd4,
        op_slt  = 4'd5,
        op_sltu = 4'd6,
        op_sge  = 4'd7,
        op_sll  = 4'd8,
        op_srl  = 4'd9,
        op_sra  = 4'd10
    } alu_op_e;

    // Decode FSM states
    typedef enum logic [1:0] {
        dec_idle = 2'd0,  // Waiting for a command
        dec_rs1  = 2'd1,  // Fetching first operand
        dec_rs2  = 2'd2,  // Fetching second operand
        dec_out  = 2'd3   // Presenting to execute
    } dec_state_e;

endpackage

`default_nettype wire

// ==== src/apb_host_port.sv ====
// APB slave for the host side
// Maps transfers to bank accesses, command issue and status reads
`timescale 1ns/1ps
`default_nettype none

module apb_host_port (
    input  logic                               clk,
    input  logic                               rstz,
    input  logic [7:0]                         paddr,
    input  logic                               psel,
    input  logic                               penable,
    input  logic                               pwrite,
    input  logic [alu_copro_pkg::data_w-1:0]   pwdata,
    output logic [alu_copro_pkg::data_w-1:0]   prdata,
    output logic                               pready,
    output logic                               host_req,
    output logic                               host_we,
    output logic [alu_copro_pkg::reg_aw-1:0]   host_addr,
    output logic [alu_copro_pkg::data_w-1:0]   host_wdata,
    input  logic                               host_gnt,
    input  logic [alu_copro_pkg::data_w-1:0]   host_rdata,
    input  logic                               host_rvld,
    output logic                               cmd_vld,
    output logic [alu_copro_pkg::data_w-1:0]   cmd_word,
    input  logic                               cmd_rdy,
    input  logic                               busy,
    input  logic [alu_copro_pkg::done_cnt_w-1:0] done_cnt
);

    logic access;      // APB access phase
    logic is_reg;
    logic is_cmd;
    logic is_status;
    logic rd_wait;     // Bank read granted, data not back yet

    assign access    = psel & penable;
    assign is_reg    = (paddr <= alu_copro_pkg::addr_reg_top);
    assign is_cmd    = (paddr == alu_copro_pkg::addr_cmd);
    assign is_status = (paddr == alu_copro_pkg::addr_status);

    // Bank side, request held until grant
    assign host_req   = access & is_reg & ~rd_wait;
    assign host_we    = pwrite;
    assign host_addr  = paddr[alu_copro_pkg::reg_aw+1:2];  // Word aligned
    assign host_wdata = pwdata;

    // Command side
    assign cmd_vld  = access & is_cmd & pwrite;
    assign cmd_word = pwdata;

    always_ff @(posedge clk or negedge rstz) begin
        if (!rstz) begin
            rd_wait <= 1'b0;
        end else if (host_rvld) begin
            rd_wait <= 1'b0;                    // Data arrives, transfer ends
        end else if (host_req && host_gnt && !pwrite) begin
            rd_wait <= 1'b1;
        end
    end

    // Transfer completion per target
    always_comb begin
        if (is_reg) begin
            pready = pwrite ? (host_req & host_gnt) : (rd_wait & host_rvld);
        end else if (is_cmd && pwrite) begin
            pready = cmd_vld & cmd_rdy;
        end else begin
            pready = access;                    // Status and unmapped, no wait
        end
    end

    // Read data mux
    always_comb begin
        if (is_reg) begin
            prdata = host_rdata;
        end else if (is_status) begin
            prdata = {done_cnt,
                      {(alu_copro_pkg::data_w-alu_copro_pkg::done_cnt_w-1){1'b0}},
                      busy};
        end else begin
            prdata = '0;
        end
    end

endmodule

`default_nettype wire

// ==== src/bank_arbiter.sv ====
// 16x32 register bank behind one port
// Fixed priority: writeback, then decode, then host
`timescale 1ns/1ps
`default_nettype none

module bank_arbiter (
    input  logic                             clk,
    input  logic                             rstz,
    input  logic                             wb_req,
    input  logic                             wb_we,
    input  logic [alu_copro_pkg::reg_aw-1:0] wb_addr,
    input  logic [alu_copro_pkg::data_w-1:0] wb_wdata,
    output logic                             wb_gnt,
    output logic                             wb_rvld,
    input  logic                             dec_req,
    input  logic                             dec_we,
    input  logic [alu_copro_pkg::reg_aw-1:0] dec_addr,
    input  logic [alu_copro_pkg::data_w-1:0] dec_wdata,
    output logic                             dec_gnt,
    output logic                             dec_rvld,
    input  logic                             host_req,
    input  logic                             host_we,
    input  logic [alu_copro_pkg::reg_aw-1:0] host_addr,
    input  logic [alu_copro_pkg::data_w-1:0] host_wdata,
    output logic                             host_gnt,
    output logic                             host_rvld,
    output logic [alu_copro_pkg::data_w-1:0] rdata
);

    logic [alu_copro_pkg::data_w-1:0] regs [alu_copro_pkg::reg_num];

    logic                             sel_we;
    logic [alu_copro_pkg::reg_aw-1:0] sel_addr;
    logic [alu_copro_pkg::data_w-1:0] sel_wdata;

    // Same-cycle grants
    assign wb_gnt   = wb_req;
    assign dec_gnt  = dec_req & ~wb_req;
    assign host_gnt = host_req & ~wb_req & ~dec_req;

    // Steer the winner onto the port
    always_comb begin
        if (wb_gnt) begin
            sel_we    = wb_we;
            sel_addr  = wb_addr;
            sel_wdata = wb_wdata;
        end else if (dec_gnt) begin
            sel_we    = dec_we;
            sel_addr  = dec_addr;
            sel_wdata = dec_wdata;
        end else begin
            sel_we    = host_gnt & host_we;       // Idle port never writes
            sel_addr  = host_addr;
            sel_wdata = host_wdata;
        end
    end

    always_ff @(posedge clk or negedge rstz) begin
        if (!rstz) begin
            for (int i = 0; i < alu_copro_pkg::reg_num; i++) begin
                regs[i] <= '0;
            end
            wb_rvld   <= 1'b0;
            dec_rvld  <= 1'b0;
            host_rvld <= 1'b0;
        end else begin
            if (sel_we) regs[sel_addr] <= sel_wdata;
            wb_rvld   <= wb_gnt & ~wb_we;       // Read strobes one cycle later
            dec_rvld  <= dec_gnt & ~dec_we;
            host_rvld <= host_gnt & ~host_we;
        end
    end

    // Registered read data, shared by all requesters
    always_ff @(posedge clk) begin
        rdata <= regs[sel_addr];
    end

endmodule

`default_nettype wire

// ==== src/decode_stage.sv ====
// Decode stage with pending-destination scoreboard
// Accepts a command, fetches rs1 and rs2 from the bank, hands it to execute
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
    input  logic                             clk,
    input  logic                             rstz,
    input  logic                             cmd_vld,
    input  logic [alu_copro_pkg::data_w-1:0] cmd_word,
    output logic                             cmd_rdy,
    output logic                             dec_req,
    output logic [alu_copro_pkg::reg_aw-1:0] dec_addr,
    input  logic                             dec_gnt,
    input  logic                             dec_rvld,
    input  logic [alu_copro_pkg::data_w-1:0] rdata,
    input  logic                             wb_done,
    input  logic [alu_copro_pkg::reg_aw-1:0] wb_rd,
    output logic                             pending,
    output logic                             ex_vld,
    input  logic                             ex_rdy,
    output alu_copro_pkg::alu_op_e           ex_op,
    output logic [alu_copro_pkg::reg_aw-1:0] ex_rd,
    output logic [alu_copro_pkg::data_w-1:0] ex_op1,
    output logic [alu_copro_pkg::data_w-1:0] ex_op2
);

    alu_copro_pkg::dec_state_e state;

    logic [alu_copro_pkg::reg_num-1:0] sb;       // One bit per register
    logic [alu_copro_pkg::reg_num-1:0] sb_nxt;
    logic [alu_copro_pkg::reg_aw-1:0]  rs1_q, rs2_q;
    logic                              rd_wait;  // Operand read in flight
    logic                              hazard;

    // Sources and destination must all be free, rd too so writes stay ordered
    assign hazard  = sb[cmd_word[19:16]] | sb[cmd_word[27:24]] | sb[cmd_word[11:8]];
    assign cmd_rdy = (state == alu_copro_pkg::dec_idle) & ~hazard;

    assign dec_req  = ((state == alu_copro_pkg::dec_rs1) ||
                       (state == alu_copro_pkg::dec_rs2)) && !rd_wait;
    assign dec_addr = (state == alu_copro_pkg::dec_rs1) ? rs1_q : rs2_q;

    assign ex_vld  = (state == alu_copro_pkg::dec_out);
    assign pending = |sb;

    // Release first, then mark the newly accepted destination
    always_comb begin
        sb_nxt = sb;
        if (wb_done) sb_nxt[wb_rd] = 1'b0;
        if (cmd_vld && cmd_rdy) sb_nxt[cmd_word[11:8]] = 1'b1;
    end

    always_ff @(posedge clk or negedge rstz) begin
        if (!rstz) begin
            state   <= alu_copro_pkg::dec_idle;
            sb      <= '0;
            rd_wait <= 1'b0;
        end else begin
            sb <= sb_nxt;
            if (dec_req && dec_gnt) rd_wait <= 1'b1;
            if (dec_rvld) rd_wait <= 1'b0;
            case (state)
                alu_copro_pkg::dec_idle: if (cmd_vld && cmd_rdy) state <= alu_copro_pkg::dec_rs1;
                alu_copro_pkg::dec_rs1:  if (dec_rvld) state <= alu_copro_pkg::dec_rs2;
                alu_copro_pkg::dec_rs2:  if (dec_rvld) state <= alu_copro_pkg::dec_out;
                default:                 if (ex_rdy) state <= alu_copro_pkg::dec_idle;
            endcase
        end
    end

    // Command fields and operands, held while ex_vld waits
    always_ff @(posedge clk) begin
        if (cmd_vld && cmd_rdy) begin
            ex_op <= alu_copro_pkg::alu_op_e'(cmd_word[3:0]);
            ex_rd <= cmd_word[11:8];
            rs1_q <= cmd_word[19:16];
            rs2_q <= cmd_word[27:24];
        end
        if (dec_rvld && state == alu_copro_pkg::dec_rs1) ex_op1 <= rdata;
        if (dec_rvld && state == alu_copro_pkg::dec_rs2) ex_op2 <= rdata;
    end

endmodule

`default_nettype wire

// ==== src/alu_ex.sv ====
// Execute stage, one registered result per accepted operation
// Valid/ready on both sides, holds its result under back-pressure
`timescale 1ns/1ps
`default_nettype none

module alu_ex (
    input  logic                             clk,
    input  logic                             rstz,
    input  logic                             in_vld,
    output logic                             in_rdy,
    input  alu_copro_pkg::alu_op_e           op,
    input  logic [alu_copro_pkg::reg_aw-1:0] rd_in,
    input  logic [alu_copro_pkg::data_w-1:0] op1,
    input  logic [alu_copro_pkg::data_w-1:0] op2,
    output logic                             out_vld,
    input  logic                             out_rdy,
    output logic [alu_copro_pkg::data_w-1:0] result,
    output logic [alu_copro_pkg::reg_aw-1:0] rd_out
);

    logic [alu_copro_pkg::data_w-1:0] r_add, r_sub;
    logic [alu_copro_pkg::data_w-1:0] r_and, r_or, r_xor;
    logic [alu_copro_pkg::data_w-1:0] r_sll, r_srl, r_sra;
    logic                             lt_s, lt_u;
    logic [4:0]                       shamt;
    logic [alu_copro_pkg::data_w-1:0] res_nxt;

    // Adder and subtractor
    assign r_add = op1 + op2;
    assign r_sub = op1 - op2;

    // Logic unit
    assign r_and = op1 & op2;
    assign r_or  = op1 | op2;
    assign r_xor = op1 ^ op2;

    // Comparator
    assign lt_s = $signed(op1) < $signed(op2);
    assign lt_u = op1 < op2;

    // Barrel shifter, low five bits of op2
    assign shamt = op2[4:0];
    assign r_sll = op1 << shamt;
    assign r_srl = op1 >> shamt;
    assign r_sra = $unsigned($signed(op1) >>> shamt);  // Sign fill

    always_comb begin
        case (op)
            alu_copro_pkg::op_add:  res_nxt = r_add;
            alu_copro_pkg::op_sub:  res_nxt = r_sub;
            alu_copro_pkg::op_and:  res_nxt = r_and;
            alu_copro_pkg::op_or:   res_nxt = r_or;
            alu_copro_pkg::op_xor:  res_nxt = r_xor;
            alu_copro_pkg::op_slt:  res_nxt = {{(alu_copro_pkg::data_w-1){1'b0}}, lt_s};
            alu_copro_pkg::op_sltu: res_nxt = {{(alu_copro_pkg::data_w-1){1'b0}}, lt_u};
            alu_copro_pkg::op_sge:  res_nxt = {{(alu_copro_pkg::data_w-1){1'b0}}, ~lt_s};
            alu_copro_pkg::op_sll:  res_nxt = r_sll;
            alu_copro_pkg::op_srl:  res_nxt = r_srl;
            alu_copro_pkg::op_sra:  res_nxt = r_sra;
            default:                res_nxt = '0;      // Reserved codes
        endcase
    end

    // Empty or draining this cycle
    assign in_rdy = ~out_vld | out_rdy;

    always_ff @(posedge clk or negedge rstz) begin
        if (!rstz) begin
            out_vld <= 1'b0;
        end else if (in_vld && in_rdy) begin
            out_vld <= 1'b1;
        end else if (out_vld && out_rdy) begin
            out_vld <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (in_vld && in_rdy) begin
            result <= res_nxt;
            rd_out <= rd_in;
        end
    end

endmodule

`default_nettype wire

// ==== src/writeback_stage.sv ====
// Writeback stage, one result buffer
// Writes the bank, frees the scoreboard entry and counts completions
`timescale 1ns/1ps
`default_nettype none

module writeback_stage (
    input  logic                                 clk,
    input  logic                                 rstz,
    input  logic                                 in_vld,
    output logic                                 in_rdy,
    input  logic [alu_copro_pkg::data_w-1:0]     result,
    input  logic [alu_copro_pkg::reg_aw-1:0]     rd,
    output logic                                 wb_req,
    output logic [alu_copro_pkg::reg_aw-1:0]     wb_addr,
    output logic [alu_copro_pkg::data_w-1:0]     wb_wdata,
    input  logic                                 wb_gnt,
    output logic                                 wb_done,
    output logic [alu_copro_pkg::reg_aw-1:0]     wb_rd,
    output logic [alu_copro_pkg::done_cnt_w-1:0] done_cnt
);

    logic full;

    assign in_rdy  = ~full | wb_gnt;   // Reopens in the grant cycle
    assign wb_req  = full;
    assign wb_done = full & wb_gnt;
    assign wb_rd   = wb_addr;

    always_ff @(posedge clk or negedge rstz) begin
        if (!rstz) begin
            full     <= 1'b0;
            done_cnt <= '0;
        end else begin
            if (in_vld && in_rdy) full <= 1'b1;
            else if (wb_done) full <= 1'b0;
            if (wb_done) done_cnt <= done_cnt + 1'b1;   // Wraps at 2^16
        end
    end

    always_ff @(posedge clk) begin
        if (in_vld && in_rdy) begin
            wb_addr  <= rd;
            wb_wdata <= result;
        end
    end

endmodule

`default_nettype wire

// ==== src/alu_copro_top.sv ====
// ALU coprocessor top level
// APB host port, decode/execute/writeback pipeline and the shared bank
`timescale 1ns/1ps
`default_nettype none

module alu_copro_top (
    input  logic                             clk,
    input  logic                             rstz,
    input  logic [7:0]                       paddr,
    input  logic                             psel,
    input  logic                             penable,
    input  logic                             pwrite,
    input  logic [alu_copro_pkg::data_w-1:0] pwdata,
    output logic [alu_copro_pkg::data_w-1:0] prdata,
    output logic                             pready
);

    // Host to bank and decode
    logic                                 host_req, host_we, host_gnt, host_rvld;
    logic [alu_copro_pkg::reg_aw-1:0]     host_addr;
    logic [alu_copro_pkg::data_w-1:0]     host_wdata, cmd_word, rdata;
    logic                                 cmd_vld, cmd_rdy, busy, pending;
    // Decode
    logic                                 dec_req, dec_gnt, dec_rvld;
    logic [alu_copro_pkg::reg_aw-1:0]     dec_addr;
    logic                                 ex_vld, ex_rdy;
    alu_copro_pkg::alu_op_e               ex_op;
    logic [alu_copro_pkg::reg_aw-1:0]     ex_rd;
    logic [alu_copro_pkg::data_w-1:0]     ex_op1, ex_op2;
    // Execute to writeback
    logic                                 wbk_vld, wbk_rdy;
    logic [alu_copro_pkg::data_w-1:0]     wbk_result;
    logic [alu_copro_pkg::reg_aw-1:0]     wbk_rd;
    // Writeback
    logic                                 wb_req, wb_gnt, wb_done;
    logic [alu_copro_pkg::reg_aw-1:0]     wb_addr, wb_rd;
    logic [alu_copro_pkg::data_w-1:0]     wb_wdata;
    logic [alu_copro_pkg::done_cnt_w-1:0] done_cnt;

    assign busy = pending | ex_vld | wbk_vld;   // Anything still in flight

    apb_host_port i_apb_host_port (
        .clk, .rstz, .paddr, .psel, .penable, .pwrite, .pwdata, .prdata, .pready,
        .host_req, .host_we, .host_addr, .host_wdata, .host_gnt, .host_rdata(rdata),
        .host_rvld, .cmd_vld, .cmd_word, .cmd_rdy, .busy, .done_cnt
    );

    decode_stage i_decode_stage (
        .clk, .rstz, .cmd_vld, .cmd_word, .cmd_rdy, .dec_req, .dec_addr, .dec_gnt,
        .dec_rvld, .rdata, .wb_done, .wb_rd, .pending, .ex_vld, .ex_rdy, .ex_op,
        .ex_rd, .ex_op1, .ex_op2
    );

    alu_ex i_alu_ex (
        .clk, .rstz, .in_vld(ex_vld), .in_rdy(ex_rdy), .op(ex_op), .rd_in(ex_rd),
        .op1(ex_op1), .op2(ex_op2), .out_vld(wbk_vld), .out_rdy(wbk_rdy),
        .result(wbk_result), .rd_out(wbk_rd)
    );

    writeback_stage i_writeback_stage (
        .clk, .rstz, .in_vld(wbk_vld), .in_rdy(wbk_rdy), .result(wbk_result),
        .rd(wbk_rd), .wb_req, .wb_addr, .wb_wdata, .wb_gnt, .wb_done, .wb_rd, .done_cnt
    );

    // Writeback only writes, decode only reads
    bank_arbiter i_bank_arbiter (
        .clk, .rstz,
        .wb_req, .wb_we(1'b1), .wb_addr, .wb_wdata, .wb_gnt, .wb_rvld(),
        .dec_req, .dec_we(1'b0), .dec_addr, .dec_wdata('0), .dec_gnt, .dec_rvld,
        .host_req, .host_we, .host_addr, .host_wdata, .host_gnt, .host_rvld,
        .rdata
    );

endmodule

`default_nettype wire

// ==== sim/alu_copro_tb.sv ====
// Self-checking testbench for the ALU coprocessor
// Drives APB transfers, mirrors the register bank and checks every read
`timescale 1ns/1ps
`default_nettype none

module alu_copro_tb;

    localparam int clk_period = 40;   // ns
    localparam int xfer_limit = 40;   // Cycles allowed per APB transfer
    localparam int max_polls  = 20;   // Status polls before giving up
    localparam int n_dir      = 24;   // Directed ALU cases
    localparam int burst_len  = 24;
    // Transfer budget with every status poll counted at its bound
    localparam int n_xfers = 17 + 32 + n_dir * (5 + max_polls)
                           + (burst_len + max_polls + 16) + 1
                           + (2 * burst_len + max_polls + 17);

    logic                             clk;
    logic                             rstz;
    logic [7:0]                       paddr;
    logic                             psel;
    logic                             penable;
    logic                             pwrite;
    logic [alu_copro_pkg::data_w-1:0] pwdata;
    logic [alu_copro_pkg::data_w-1:0] prdata;
    logic                             pready;

    logic [alu_copro_pkg::data_w-1:0] model [alu_copro_pkg::reg_num];  // Expected bank
    logic [31:0] rng_state;
    int          errors;
    int          checks;
    int          tests;
    int          cmd_count;   // Commands issued since reset
    int          test_err0;   // Error count when the current test began

    alu_copro_top i_alu_copro_top (
        .clk, .rstz, .paddr, .psel, .penable, .pwrite, .pwdata, .prdata, .pready
    );

    always #(clk_period / 2) clk = ~clk;

    function automatic logic [31:0] lcg_next();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    function automatic logic [7:0] reg_addr(input logic [3:0] idx);
        return {2'b00, idx, 2'b00};   // Word aligned register window
    endfunction

    function automatic logic [31:0] cmd_of(input logic [3:0] op, input logic [3:0] rd,
                                           input logic [3:0] rs1, input logic [3:0] rs2);
        return {4'h0, rs2, 4'h0, rs1, 4'h0, rd, 4'h0, op};
    endfunction

    // Expected result per opcode
    function automatic logic [31:0] alu_ref(input logic [3:0] op, input logic [31:0] a,
                                            input logic [31:0] b);
        logic [4:0]  sh;
        logic [31:0] fill;
        logic        lt_s;
        logic [31:0] res;
        sh   = b[4:0];
        fill = a[31] ? ~(32'hffff_ffff >> sh) : 32'h0;   // Sign bits shifted in
        lt_s = (a[31] != b[31]) ? a[31] : (a < b);      // Negative wins when signs differ
        case (alu_copro_pkg::alu_op_e'(op))
            alu_copro_pkg::op_add:  res = a + b;
            alu_copro_pkg::op_sub:  res = a - b;
            alu_copro_pkg::op_and:  res = a & b;
            alu_copro_pkg::op_or:   res = a | b;
            alu_copro_pkg::op_xor:  res = a ^ b;
            alu_copro_pkg::op_slt:  res = {31'd0, lt_s};
            alu_copro_pkg::op_sltu: res = {31'd0, a < b};
            alu_copro_pkg::op_sge:  res = {31'd0, ~lt_s};
            alu_copro_pkg::op_sll:  res = a << sh;
            alu_copro_pkg::op_srl:  res = a >> sh;
            alu_copro_pkg::op_sra:  res = (a >> sh) | fill;
            default:                res = 32'h0;   // Reserved
        endcase
        return res;
    endfunction

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Mismatch %s: expected %08h, actual %08h", name, expected, actual);
        end
    endtask

    // Setup, access, then wait for pready sampled mid-cycle
    task automatic apb_xfer(input logic write, input logic [7:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata);
        int   cycles;
        logic done;
        cycles = 0;
        done   = 1'b0;
        rdata  = 32'h0;
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= write;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clk);
        penable <= 1'b1;
        while (!done && cycles < xfer_limit) begin
            @(negedge clk);
            if (pready) begin
                done  = 1'b1;
                rdata = prdata;   // Stable until the closing edge
            end else begin
                cycles++;
            end
        end
        if (!done) begin
            errors++;
            $display("APB transfer to address %02h got no pready in %0d cycles",
                     addr, xfer_limit);
        end
        @(posedge clk);   // Transfer ends on this edge
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
        logic [31:0] unused;
        apb_xfer(1'b1, addr, data, unused);
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
        apb_xfer(1'b0, addr, 32'h0, data);
    endtask

    task automatic wait_idle(input string name);
        logic [31:0] st;
        int          polls;
        polls = 0;
        st    = 32'h1;
        while (st[0] && polls < max_polls) begin
            apb_read(alu_copro_pkg::addr_status, st);
            polls++;
        end
        if (st[0]) begin
            errors++;
            $display("%s: pipeline still busy after %0d status polls", name, max_polls);
        end
    endtask

    // Issue one command and update the model in program order
    task automatic issue_cmd(input logic [3:0] op, input logic [3:0] rd,
                             input logic [3:0] rs1, input logic [3:0] rs2);
        apb_write(alu_copro_pkg::addr_cmd, cmd_of(op, rd, rs1, rs2));
        model[rd] = alu_ref(op, model[rs1], model[rs2]);
        cmd_count++;
    endtask

    task automatic check_all(input string name);
        logic [31:0] got;
        for (int i = 0; i < alu_copro_pkg::reg_num; i++) begin
            apb_read(reg_addr(4'(i)), got);
            check($sformatf("%s r%0d", name, i), model[i], got);
        end
    endtask

    task automatic check_status(input string name);
        logic [31:0] st;
        apb_read(alu_copro_pkg::addr_status, st);
        check(name, {cmd_count[15:0], 15'd0, 1'b0}, st);   // Idle with count mod 2^16
    endtask

    task automatic run_case(input string name, input logic [3:0] op,
                            input logic [31:0] a, input logic [31:0] b);
        logic [31:0] got;
        logic [31:0] stale;
        stale = ~alu_ref(op, a, b);   // Destination starts unlike the expected result
        apb_write(reg_addr(4'd1), a);
        model[1] = a;
        apb_write(reg_addr(4'd2), b);
        model[2] = b;
        apb_write(reg_addr(4'd3), stale);
        model[3] = stale;
        issue_cmd(op, 4'd3, 4'd1, 4'd2);
        wait_idle(name);
        apb_read(reg_addr(4'd3), got);
        check(name, model[3], got);
    endtask

    task automatic end_test(input string name);
        tests++;
        $display("%-16s %s, %0d errors", name, (errors == test_err0) ? "ok" : "FAIL",
                 errors - test_err0);
        test_err0 = errors;
    endtask

    initial begin
        logic [31:0] r;
        logic [31:0] got;
        logic [3:0]  prev;
        logic [3:0]  idx;
        clk       = 1'b0;
        rstz      <= 1'b0;
        paddr     <= 8'h00;
        psel      <= 1'b0;
        penable   <= 1'b0;
        pwrite    <= 1'b0;
        pwdata    <= 32'h0;
        rng_state = 32'hbff3_d764;
        errors    = 0;
        checks    = 0;
        tests     = 0;
        cmd_count = 0;
        test_err0 = 0;
        for (int i = 0; i < alu_copro_pkg::reg_num; i++) model[i] = 32'h0;
        repeat (5) @(posedge clk);
        rstz <= 1'b1;

        check_all("reset_state");            // Bank cleared by reset
        check_status("reset_state status");
        end_test("reset_state");

        for (int i = 0; i < alu_copro_pkg::reg_num; i++) begin
            model[i] = lcg_next();
            apb_write(reg_addr(4'(i)), model[i]);
        end
        check_all("reg_readback");
        end_test("reg_readback");

        run_case("add_overflow", alu_copro_pkg::op_add, 32'h7fff_ffff, 32'h0000_0001);
        run_case("add_wrap", alu_copro_pkg::op_add, 32'hffff_ffff, 32'h0000_0002);
        run_case("sub_negative", alu_copro_pkg::op_sub, 32'h0000_0000, 32'h0000_0001);
        run_case("sub_equal", alu_copro_pkg::op_sub, 32'h1234_5678, 32'h1234_5678);
        run_case("and", alu_copro_pkg::op_and, 32'hf0f0_f0f0, 32'hff00_ff00);
        run_case("or", alu_copro_pkg::op_or, 32'h0f0f_0000, 32'h00f0_00f0);
        run_case("xor_equal", alu_copro_pkg::op_xor, 32'ha5a5_a5a5, 32'ha5a5_a5a5);
        run_case("xor", alu_copro_pkg::op_xor, 32'hffff_0000, 32'h0ff0_0ff0);
        run_case("slt_neg_pos", alu_copro_pkg::op_slt, 32'hffff_ffff, 32'h0000_0001);
        run_case("slt_pos_neg", alu_copro_pkg::op_slt, 32'h0000_0001, 32'hffff_ffff);
        run_case("slt_equal", alu_copro_pkg::op_slt, 32'h8000_0000, 32'h8000_0000);
        run_case("sltu_small", alu_copro_pkg::op_sltu, 32'h0000_0001, 32'hffff_ffff);
        run_case("sltu_wrap", alu_copro_pkg::op_sltu, 32'hffff_ffff, 32'h0000_0001);
        run_case("sltu_equal", alu_copro_pkg::op_sltu, 32'h0000_0007, 32'h0000_0007);
        run_case("sge_negative", alu_copro_pkg::op_sge, 32'hffff_fffb, 32'h0000_0003);
        run_case("sge_equal", alu_copro_pkg::op_sge, 32'h8000_0000, 32'h8000_0000);
        run_case("sll_by_0", alu_copro_pkg::op_sll, 32'h89ab_cdef, 32'h0000_0000);
        run_case("sll_by_31", alu_copro_pkg::op_sll, 32'h0000_0003, 32'h0000_001f);
        run_case("srl_by_31", alu_copro_pkg::op_srl, 32'h8000_0000, 32'h0000_001f);
        run_case("srl_high_bits", alu_copro_pkg::op_srl, 32'hf000_0000, 32'hffff_ffe4);
        run_case("sra_by_31", alu_copro_pkg::op_sra, 32'h8000_0000, 32'h0000_001f);
        run_case("sra_by_0", alu_copro_pkg::op_sra, 32'hc000_0001, 32'h0000_0020);
        run_case("reserved_11", 4'd11, 32'h1111_1111, 32'h2222_2222);
        run_case("reserved_15", 4'd15, 32'hffff_ffff, 32'hffff_ffff);
        end_test("alu_ops");

        // Each command reads the previous destination without polling between
        prev = 4'd3;
        for (int i = 0; i < burst_len; i++) begin
            r = lcg_next();
            issue_cmd(r[31:28], r[27:24], prev, r[23:20]);
            prev = r[27:24];
        end
        wait_idle("dependent_burst");
        check_all("dependent_burst");
        end_test("dependent_burst");

        check_status("done_count");
        end_test("done_count");

        // Commands write only r0..r7 while host reads of r8..r15 compete for the bank
        for (int i = 0; i < burst_len; i++) begin
            r = lcg_next();
            issue_cmd(r[31:28], {1'b0, r[26:24]}, r[23:20], r[19:16]);
            idx = {1'b1, r[14:12]};
            apb_read(reg_addr(idx), got);
            check($sformatf("contention r%0d", idx), model[idx], got);
        end
        wait_idle("contention");
        check_all("contention");
        check_status("contention status");
        end_test("contention");

        $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // Watchdog sized from the transfer budget
    initial begin
        #(n_xfers * xfer_limit * clk_period);
        $display("Timeout: run did not finish within %0d transfer slots", n_xfers);
        $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
src/alu_copro_pkg.sv
src/apb_host_port.sv
src/bank_arbiter.sv
src/decode_stage.sv
src/alu_ex.sv
src/writeback_stage.sv
src/alu_copro_top.sv
sim/alu_copro_tb.sv

// ==== Makefile ====
# Verilator build and run for the ALU coprocessor testbench

VERILATOR ?= verilator
TOP       ?= alu_copro_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -j 0

SRCS := $(wildcard src/*.sv sim/*.sv)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Fails unless the pass line appears in the output
run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'test passed'

clean:
	rm -rf $(OBJ_DIR)
